/* Bender.yml */
package:
  name: vreg

export_include_dirs:
  - include

sources:
  - files:
      - verilog/vreg_pkg.sv
      - verilog/bus_sync.sv
      - verilog/tick_timer.sv
      - verilog/vram_channel.sv
      - verilog/sys_ctrl_regs.sv
      - verilog/vreg_top.sv
  - target: test
    files:
      - testbench/vreg_properties.sv
      - testbench/vreg_tb.sv

/* include/vreg_consts.svh */
/*
 * shared constants of the video register block
 * data and bus widths, register count, timer divisor, reset values
 */
`ifndef VREG_CONSTS_SVH
`define VREG_CONSTS_SVH

`define VREG_DATA_W     16          // register and VRAM word width
`define VREG_BYTE_W     8           // host bus width
`define VREG_MASK_W     4           // nibble write mask and interrupt mask

`define VREG_REG_CNT    16          // register numbers on the host bus

`define VREG_TIMER_DIV  16          // clocks per timer tick

`define VREG_WRMASK_RST 4'hF        // all nibbles written after reset

`endif

/* testbench/vreg_patterns.txt */
# columns: op reg bytesel byte expect, all hex; expect is checked on R lines
# BUSY drives busy_i, IMASK checks intr_mask_o, TIMER idles byte cycles between two reads
R 2 1 00 00
R 3 0 00 00
R 4 1 00 00
R 5 1 00 00
R 6 1 00 00
R 8 0 00 00
R 8 1 00 0f
IMASK 0 0 00 00
TIMER 9 1 40 00
W 4 0 00 00
W 4 1 03 00
W 5 0 12 00
W 5 1 34 00
R 4 1 00 03
R 5 0 00 12
R 5 1 00 34
R 1 0 00 00
R c 1 00 00
W 5 0 00 00
W 5 1 10 00
W 6 0 ab 00
W 6 1 cd 00
W 7 0 55 00
W 7 1 66 00
R 5 1 00 16
W 2 0 00 00
W 2 1 03 00
R 2 1 00 03
W 3 0 00 00
W 3 1 10 00
WAIT 0 0 00 00
R 6 0 00 ab
R 6 1 00 cd
R 6 0 00 55
R 6 1 00 66
R 7 0 00 00
R 7 1 00 42
R 3 1 00 1c
W 8 0 05 00
IMASK 0 0 05 00
W 8 1 03 00
R 8 0 00 05
BUSY 0 0 01 00
R 8 1 00 83
BUSY 0 0 00 00
R 8 1 00 03
W 5 0 00 00
W 5 1 20 00
W 6 0 12 00
W 6 1 ff 00
W 3 1 20 00
WAIT 0 0 00 00
R 6 0 00 00
R 6 1 00 ff
TIMER 9 1 80 00

/* testbench/vreg_properties.sv */
/*
 * VRAM handshake assertions, bound into vram_channel
 */
module vreg_properties (
    input logic                clk,
    input logic                reset_i,
    input vreg_pkg::bus_cmd_t  cmd_i,
    input vreg_pkg::vram_req_t req_i,
    input logic                ack_i
);
    import vreg_pkg::*;

    logic is_data;
    logic starts_req;                       // strobe that issues a request

    assign is_data    = (cmd_i.reg_num == DATA) || (cmd_i.reg_num == DATA_2);
    assign starts_req = cmd_i.bytesel &&
                        ((cmd_i.wr_strobe && (is_data || cmd_i.reg_num == RD_ADDR)) ||
                         (cmd_i.rd_strobe && is_data));

    req_stable: assert property (@(posedge clk) disable iff (reset_i)
        req_i.sel && !ack_i |=> $stable(req_i))
        else $error("VRAM request changed while waiting for ack");

    sel_drop: assert property (@(posedge clk) disable iff (reset_i)
        req_i.sel && ack_i |=> !req_i.sel)
        else $error("VRAM sel still high after ack");

    no_overrun: assert property (@(posedge clk) disable iff (reset_i)
        req_i.sel |-> !starts_req)
        else $error("bus access started a VRAM request during an open one");

endmodule

bind vram_channel vreg_properties u_vreg_properties (
    .clk     (clk),
    .reset_i (reset_i),
    .cmd_i   (cmd_i),
    .req_i   (vram_req_o),
    .ack_i   (vram_ack_i)
);

/* testbench/vreg_tb.sv */
/*
 * testbench of the video register block
 * clock, reset, VRAM model, pattern player, checks and timeout
 */
`include "vreg_consts.svh"

module vreg_tb;
    import vreg_pkg::*;

    localparam int MAX_PAT = 64;

    logic                    clk;
    logic                    reset_i;
    bus_pins_t               bus_pins;
    logic [`VREG_BYTE_W-1:0] bus_data;
    vram_req_t               vram_req;
    logic                    vram_ack;
    logic [`VREG_DATA_W-1:0] vram_rdata;
    logic                    busy;
    logic [`VREG_MASK_W-1:0] intr_mask;

    logic [`VREG_DATA_W-1:0] vram_mem [256];
    integer                  seed;
    logic                    ack_pending;
    int                      ack_wait;

    logic [39:0]             pat_op [MAX_PAT];    // op word, right justified
    logic [3:0]              pat_reg [MAX_PAT];
    logic                    pat_bsel [MAX_PAT];
    logic [7:0]              pat_byte [MAX_PAT];
    logic [7:0]              pat_exp [MAX_PAT];
    int                      pat_cnt;
    int                      cycle_cnt = 0;
    int                      cycle_limit = 0;
    int                      mismatch_cnt = 0;
    int                      other_cnt = 0;

    vreg_top uut (
        .clk          (clk),
        .reset_i      (reset_i),
        .bus_i        (bus_pins),
        .bus_data_o   (bus_data),
        .vram_req_o   (vram_req),
        .vram_ack_i   (vram_ack),
        .vram_rdata_i (vram_rdata),
        .busy_i       (busy),
        .intr_mask_o  (intr_mask)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // VRAM model, acks 1 to 4 cycles after it sees sel
    initial begin
        seed = 2;
        ack_pending = 1'b0;
        ack_wait = 0;
        for (int i = 0; i < 256; i++) begin
            vram_mem[i] = 16'(i * 3);
        end
    end

    always @(negedge clk) begin
        if (vram_ack) begin
            vram_ack = 1'b0;                  // taken at the last posedge
            ack_pending = 1'b0;
        end else if (vram_req.sel) begin
            if (!ack_pending) begin
                ack_pending = 1'b1;
                ack_wait = $unsigned($random(seed)) % 4;
            end else if (ack_wait != 0) begin
                ack_wait = ack_wait - 1;
            end
            if (ack_wait == 0) begin
                vram_ack = 1'b1;
                if (vram_req.wr) begin
                    for (int n = 0; n < `VREG_MASK_W; n++) begin
                        if (vram_req.wrmask[n]) begin
                            vram_mem[vram_req.addr[7:0]][n*4 +: 4] = vram_req.data[n*4 +: 4];
                        end
                    end
                end else begin
                    vram_rdata = vram_mem[vram_req.addr[7:0]];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("run stopped, no progress after %0d cycles", cycle_cnt);
            $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt + 1);
            $display("Test failed");
            $finish;
        end
    end

    // one host access, cs_n low for 6 cycles then high for 4
    task automatic bus_access(input logic rd, input logic [3:0] num, input logic bsel,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        bus_pins = '{cs_n: 1'b0, rd_nwr: rd, reg_num: reg_num_e'(num),
                     bytesel: bsel, data: wdata};
        repeat (4) @(negedge clk);
        rdata = bus_data;                     // readback valid, prefetch not yet back
        repeat (2) @(negedge clk);
        bus_pins.cs_n = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    task automatic load_patterns();
        int         fd;
        int         n;
        logic [639:0] line_buf;
        fd = $fopen("testbench/vreg_patterns.txt", "r");
        pat_cnt = 0;
        if (fd == 0) begin
            $display("pattern file testbench/vreg_patterns.txt could not be opened");
            other_cnt++;
        end else begin
            while (!$feof(fd) && pat_cnt < MAX_PAT) begin
                line_buf = '0;
                void'($fgets(line_buf, fd));
                n = $sscanf(line_buf, "%s %h %h %h %h", pat_op[pat_cnt], pat_reg[pat_cnt],
                            pat_bsel[pat_cnt], pat_byte[pat_cnt], pat_exp[pat_cnt]);
                if (n == 5) begin
                    pat_cnt++;                // comment and blank lines skipped
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_ticks(input int idx);
        logic [7:0] t1;
        logic [7:0] t2;
        int         c1;
        int         expect_ticks;
        int         diff;
        bus_access(1'b1, pat_reg[idx], pat_bsel[idx], 8'h00, t1);
        c1 = cycle_cnt;
        repeat (pat_byte[idx]) @(negedge clk);
        bus_access(1'b1, pat_reg[idx], pat_bsel[idx], 8'h00, t2);
        expect_ticks = (cycle_cnt - c1) / `VREG_TIMER_DIV;
        diff = int'(8'(t2 - t1));
        if (diff + 1 < expect_ticks || diff > expect_ticks + 1) begin
            $display("MISMATCH at %0t: timer moved %0d ticks, expected %0d", $time, diff,
                     expect_ticks);
            mismatch_cnt++;
        end
    endtask

    initial begin
        logic [7:0] got;
        reset_i = 1'b1;
        bus_pins = '{cs_n: 1'b1, rd_nwr: 1'b1, reg_num: reg_num_e'(4'h0), bytesel: 1'b0,
                     data: 8'h00};
        vram_ack = 1'b0;
        vram_rdata = '0;
        busy = 1'b0;
        load_patterns();
        cycle_limit = 40 * pat_cnt + 200;
        repeat (3) @(negedge clk);
        reset_i = 1'b0;
        repeat (2) @(negedge clk);
        for (int i = 0; i < pat_cnt; i++) begin
            if (pat_op[i] == "W") begin
                bus_access(1'b0, pat_reg[i], pat_bsel[i], pat_byte[i], got);
            end else if (pat_op[i] == "R") begin
                bus_access(1'b1, pat_reg[i], pat_bsel[i], 8'h00, got);
                if (got !== pat_exp[i]) begin
                    $display("MISMATCH at %0t: reg %h byte %0d read %h, expected %h", $time,
                             pat_reg[i], pat_bsel[i], got, pat_exp[i]);
                    mismatch_cnt++;
                end
            end else if (pat_op[i] == "WAIT") begin
                while (vram_req.sel || vram_ack) @(negedge clk);
            end else if (pat_op[i] == "BUSY") begin
                busy = pat_byte[i][0];
            end else if (pat_op[i] == "IMASK") begin
                if (intr_mask !== pat_byte[i][`VREG_MASK_W-1:0]) begin
                    $display("MISMATCH at %0t: intr_mask_o %h, expected %h", $time, intr_mask,
                             pat_byte[i][`VREG_MASK_W-1:0]);
                    mismatch_cnt++;
                end
            end else if (pat_op[i] == "TIMER") begin
                check_ticks(i);
            end else begin
                $display("pattern line %0d has an unknown operation", i);
                other_cnt++;
            end
        end
        $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog/bus_sync.sv */
/*
 * host bus synchronizer
 * two flop stages, chip select fall detect, read and write strobes
 */
module bus_sync (
    input  logic                clk,
    input  logic                reset_i,
    input  vreg_pkg::bus_pins_t bus_i,
    output vreg_pkg::bus_cmd_t  cmd_o
);
    import vreg_pkg::*;

    bus_pins_t               pins_s1;       // first sync stage
    bus_pins_t               pins_s2;       // second sync stage
    logic                    cs_n_prev;     // pins_s2.cs_n one cycle back
    logic                    cs_fall;
    logic                    wr_stb;
    logic                    rd_stb;
    reg_num_e                lat_reg_num;
    logic                    lat_bytesel;
    logic [`VREG_BYTE_W-1:0] lat_data;

    assign cs_fall = !pins_s2.cs_n && cs_n_prev;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pins_s1   <= '1;                // idle bus, cs_n high
            pins_s2   <= '1;
            cs_n_prev <= 1'b1;
            wr_stb    <= 1'b0;
            rd_stb    <= 1'b0;
        end else begin
            pins_s1   <= bus_i;
            pins_s2   <= pins_s1;
            cs_n_prev <= pins_s2.cs_n;
            wr_stb    <= cs_fall && !pins_s2.rd_nwr;
            rd_stb    <= cs_fall && pins_s2.rd_nwr;
        end
    end

    // access fields stay put for readback until the next access
    always_ff @(posedge clk) begin
        if (cs_fall) begin
            lat_reg_num <= pins_s2.reg_num;
            lat_bytesel <= pins_s2.bytesel;
            lat_data    <= pins_s2.data;
        end
    end

    assign cmd_o = '{wr_strobe: wr_stb, rd_strobe: rd_stb, reg_num: lat_reg_num,
                     bytesel: lat_bytesel, data: lat_data};

endmodule

/* verilog/sys_ctrl_regs.sv */
/*
 * system control register and readback
 * interrupt mask, VRAM nibble write mask, byte readback multiplexer
 */
`include "vreg_consts.svh"

module sys_ctrl_regs (
    input  logic                    clk,
    input  logic                    reset_i,
    input  vreg_pkg::bus_cmd_t      cmd_i,
    input  logic                    busy_i,
    input  logic [`VREG_DATA_W-1:0] ticks_i,
    input  logic [`VREG_DATA_W-1:0] rd_incr_i,
    input  logic [`VREG_DATA_W-1:0] rd_addr_i,
    input  logic [`VREG_DATA_W-1:0] wr_incr_i,
    input  logic [`VREG_DATA_W-1:0] wr_addr_i,
    input  logic [`VREG_DATA_W-1:0] rd_data_i,
    output logic [`VREG_MASK_W-1:0] intr_mask_o,
    output logic [`VREG_MASK_W-1:0] wrmask_o,
    output logic [`VREG_BYTE_W-1:0] bus_data_o
);
    import vreg_pkg::*;

    logic [`VREG_DATA_W-1:0] sel_word;      // addressed register as a word
    logic [`VREG_DATA_W-1:0] sys_word;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_mask_o <= '0;
            wrmask_o    <= `VREG_WRMASK_RST;
        end else if (cmd_i.wr_strobe && cmd_i.reg_num == SYS_CTRL) begin
            if (cmd_i.bytesel) begin
                wrmask_o    <= cmd_i.data[`VREG_MASK_W-1:0];
            end else begin
                intr_mask_o <= cmd_i.data[`VREG_MASK_W-1:0];
            end
        end
    end

    // even byte: intr mask, odd byte: busy in bit 7, write mask low
    assign sys_word = {4'b0, intr_mask_o, busy_i, 3'b0, wrmask_o};

    always_comb begin
        case (cmd_i.reg_num)
            RD_INCR:      sel_word = rd_incr_i;
            RD_ADDR:      sel_word = rd_addr_i;
            WR_INCR:      sel_word = wr_incr_i;
            WR_ADDR:      sel_word = wr_addr_i;
            DATA, DATA_2: sel_word = rd_data_i;     // last word read
            SYS_CTRL:     sel_word = sys_word;
            TIMER:        sel_word = ticks_i;
            default:      sel_word = '0;            // unused numbers
        endcase
        if (cmd_i.bytesel) begin
            bus_data_o = sel_word[`VREG_BYTE_W-1:0];
        end else begin
            bus_data_o = sel_word[`VREG_DATA_W-1:`VREG_BYTE_W];
        end
    end

endmodule

/* verilog/tick_timer.sv */
/*
 * free-running tick timer
 * prescaler plus 16-bit wrapping count
 */
`include "vreg_consts.svh"

module tick_timer (
    input  logic                    clk,
    input  logic                    reset_i,
    output logic [`VREG_DATA_W-1:0] ticks_o
);
    localparam int PRE_W = $clog2(`VREG_TIMER_DIV);

    logic [PRE_W-1:0] prescale;             // clocks within the current tick

    always_ff @(posedge clk) begin
        if (reset_i) begin
            prescale <= '0;
            ticks_o  <= '0;
        end else if (prescale == PRE_W'(`VREG_TIMER_DIV - 1)) begin
            prescale <= '0;
            ticks_o  <= ticks_o + 1'b1;     // wraps at top
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

endmodule

/* verilog/vram_channel.sv */
/*
 * VRAM access channel
 * read/write address and increment registers, request issue,
 * ack handling with address advance, read data capture
 */
`include "vreg_consts.svh"

module vram_channel (
    input  logic                    clk,
    input  logic                    reset_i,
    input  vreg_pkg::bus_cmd_t      cmd_i,
    input  logic [`VREG_MASK_W-1:0] wrmask_i,
    output vreg_pkg::vram_req_t     vram_req_o,
    input  logic                    vram_ack_i,
    input  logic [`VREG_DATA_W-1:0] vram_rdata_i,
    output logic [`VREG_DATA_W-1:0] rd_incr_o,
    output logic [`VREG_DATA_W-1:0] rd_addr_o,
    output logic [`VREG_DATA_W-1:0] wr_incr_o,
    output logic [`VREG_DATA_W-1:0] wr_addr_o,
    output logic [`VREG_DATA_W-1:0] rd_data_o
);
    import vreg_pkg::*;

    localparam int DW = `VREG_DATA_W;
    localparam int BW = `VREG_BYTE_W;

    logic                    req_sel;
    logic                    req_wr;
    logic [`VREG_MASK_W-1:0] req_wrmask;
    logic [DW-1:0]           req_addr;
    logic [DW-1:0]           req_data;
    logic [BW-1:0]           data_even;     // high byte of next write word

    logic                    wr_even;
    logic                    wr_odd;
    logic                    rd_odd;
    logic                    is_data;
    logic                    start_rd;
    logic                    start_wr;
    logic                    ack_done;

    assign wr_even  = cmd_i.wr_strobe && !cmd_i.bytesel;
    assign wr_odd   = cmd_i.wr_strobe && cmd_i.bytesel;
    assign rd_odd   = cmd_i.rd_strobe && cmd_i.bytesel;
    assign is_data  = (cmd_i.reg_num == DATA) || (cmd_i.reg_num == DATA_2);
    assign start_rd = (wr_odd && cmd_i.reg_num == RD_ADDR) || (rd_odd && is_data);
    assign start_wr = wr_odd && is_data;
    assign ack_done = req_sel && vram_ack_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            req_sel    <= 1'b0;
            req_wr     <= 1'b0;
            req_wrmask <= `VREG_WRMASK_RST;
            rd_incr_o  <= '0;
            rd_addr_o  <= '0;
            wr_incr_o  <= '0;
            wr_addr_o  <= '0;
            rd_data_o  <= '0;
        end else begin
            if (ack_done) begin
                req_sel <= 1'b0;
                req_wr  <= 1'b0;
                if (req_wr) begin
                    wr_addr_o <= wr_addr_o + wr_incr_o;
                end else begin
                    rd_data_o <= vram_rdata_i;
                    rd_addr_o <= rd_addr_o + rd_incr_o;
                end
            end

            if (wr_even) begin
                case (cmd_i.reg_num)
                    RD_INCR: rd_incr_o[DW-1:BW] <= cmd_i.data;
                    RD_ADDR: rd_addr_o[DW-1:BW] <= cmd_i.data;
                    WR_INCR: wr_incr_o[DW-1:BW] <= cmd_i.data;
                    WR_ADDR: wr_addr_o[DW-1:BW] <= cmd_i.data;
                    default: ;
                endcase
            end

            if (wr_odd) begin
                case (cmd_i.reg_num)
                    RD_INCR: rd_incr_o[BW-1:0] <= cmd_i.data;
                    RD_ADDR: rd_addr_o[BW-1:0] <= cmd_i.data;   // read issued below
                    WR_INCR: wr_incr_o[BW-1:0] <= cmd_i.data;
                    WR_ADDR: wr_addr_o[BW-1:0] <= cmd_i.data;
                    default: ;
                endcase
            end

            if (start_rd || start_wr) begin
                req_sel    <= 1'b1;
                req_wr     <= start_wr;
                req_wrmask <= wrmask_i;
            end
        end
    end

    // request payload, held while sel is high
    always_ff @(posedge clk) begin
        if (wr_even && is_data) begin
            data_even <= cmd_i.data;
        end
        if (start_rd) begin
            if (cmd_i.reg_num == RD_ADDR) begin
                req_addr <= {rd_addr_o[DW-1:BW], cmd_i.data};   // new address
            end else begin
                req_addr <= rd_addr_o;                          // prefetch
            end
        end
        if (start_wr) begin
            req_addr <= wr_addr_o;
            req_data <= {data_even, cmd_i.data};
        end
    end

    assign vram_req_o = '{sel: req_sel, wr: req_wr, wrmask: req_wrmask,
                          addr: req_addr, data: req_data};

endmodule

/* verilog/vreg_pkg.sv */
/*
 * types of the video register block
 * register numbers, raw host bus, synchronized bus command, VRAM request
 */
`include "vreg_consts.svh"

package vreg_pkg;

    // numbers 0, 1 and a..f belong to dropped registers and stay unnamed
    typedef enum logic [$clog2(`VREG_REG_CNT)-1:0] {
        RD_INCR  = 4'h2,
        RD_ADDR  = 4'h3,
        WR_INCR  = 4'h4,
        WR_ADDR  = 4'h5,
        DATA     = 4'h6,
        DATA_2   = 4'h7,
        SYS_CTRL = 4'h8,
        TIMER    = 4'h9
    } reg_num_e;

    typedef struct packed {
        logic                    cs_n;      // active low select
        logic                    rd_nwr;    // 1 = read
        reg_num_e                reg_num;
        logic                    bytesel;   // 0 = even (high) byte
        logic [`VREG_BYTE_W-1:0] data;
    } bus_pins_t;

    typedef struct packed {
        logic                    wr_strobe; // one cycle per access
        logic                    rd_strobe;
        reg_num_e                reg_num;   // held until next access
        logic                    bytesel;
        logic [`VREG_BYTE_W-1:0] data;
    } bus_cmd_t;

    typedef struct packed {
        logic                    sel;       // held until ack
        logic                    wr;
        logic [`VREG_MASK_W-1:0] wrmask;    // one bit per nibble
        logic [`VREG_DATA_W-1:0] addr;
        logic [`VREG_DATA_W-1:0] data;
    } vram_req_t;

endpackage

/* verilog/vreg_top.sv */
/*
 * top of the host register block
 * bus synchronizer, tick timer, VRAM channel, system control
 */
`include "vreg_consts.svh"

module vreg_top (
    input  logic                    clk,
    input  logic                    reset_i,
    input  vreg_pkg::bus_pins_t     bus_i,
    output logic [`VREG_BYTE_W-1:0] bus_data_o,
    output vreg_pkg::vram_req_t     vram_req_o,
    input  logic                    vram_ack_i,
    input  logic [`VREG_DATA_W-1:0] vram_rdata_i,
    input  logic                    busy_i,
    output logic [`VREG_MASK_W-1:0] intr_mask_o
);
    import vreg_pkg::*;

    bus_cmd_t                cmd;           // synchronized host access
    logic [`VREG_DATA_W-1:0] ticks;
    logic [`VREG_MASK_W-1:0] wrmask;
    logic [`VREG_DATA_W-1:0] rd_incr;
    logic [`VREG_DATA_W-1:0] rd_addr;
    logic [`VREG_DATA_W-1:0] wr_incr;
    logic [`VREG_DATA_W-1:0] wr_addr;
    logic [`VREG_DATA_W-1:0] rd_data;

    bus_sync u_bus_sync (
        .clk     (clk),
        .reset_i (reset_i),
        .bus_i   (bus_i),
        .cmd_o   (cmd)
    );

    tick_timer u_tick_timer (
        .clk     (clk),
        .reset_i (reset_i),
        .ticks_o (ticks)
    );

    vram_channel u_vram_channel (
        .clk          (clk),
        .reset_i      (reset_i),
        .cmd_i        (cmd),
        .wrmask_i     (wrmask),
        .vram_req_o   (vram_req_o),
        .vram_ack_i   (vram_ack_i),
        .vram_rdata_i (vram_rdata_i),
        .rd_incr_o    (rd_incr),
        .rd_addr_o    (rd_addr),
        .wr_incr_o    (wr_incr),
        .wr_addr_o    (wr_addr),
        .rd_data_o    (rd_data)
    );

    sys_ctrl_regs u_sys_ctrl_regs (
        .clk         (clk),
        .reset_i     (reset_i),
        .cmd_i       (cmd),
        .busy_i      (busy_i),
        .ticks_i     (ticks),
        .rd_incr_i   (rd_incr),
        .rd_addr_i   (rd_addr),
        .wr_incr_i   (wr_incr),
        .wr_addr_i   (wr_addr),
        .rd_data_i   (rd_data),
        .intr_mask_o (intr_mask_o),
        .wrmask_o    (wrmask),
        .bus_data_o  (bus_data_o)
    );

endmodule

/* vlog.f */
+incdir+include
verilog/vreg_pkg.sv
verilog/bus_sync.sv
verilog/tick_timer.sv
verilog/vram_channel.sv
verilog/sys_ctrl_regs.sv
verilog/vreg_top.sv
testbench/vreg_properties.sv
testbench/vreg_tb.sv
